/* hw/fetch_pkg.sv */
// Word-aligned fetch only; status is a single bit, so only valid and bus error can be told apart
`default_nettype none

package fetch_pkg;

    localparam int ADDR_W  = 32;                       // Fetch address width
    localparam int INSTR_W = 32;                       // Instruction word width

    typedef logic [ADDR_W-1:0]  addr_t;                // Bits 1:0 always zero
    typedef logic [INSTR_W-1:0] instr_t;

    localparam addr_t ADDR_STEP = addr_t'(4);          // One word per fetch

    // Status that travels with every fetched word
    typedef enum logic {
        FETCH_VALID = 1'b0,
        FETCH_BSERR = 1'b1                             // Bus answered with hresp high
    } fetch_status_e;

    // AHB3-Lite transfer type, only the two codes the fetch unit drives
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_NONSEQ = 2'b10
    } htrans_e;

    typedef struct packed {
        fetch_status_e status;                         // MSB
        instr_t        instr;
    } ifb_entry_t;

    // Bits needed for a free count of 0 to depth
    function automatic int free_w(input int depth);
        return $clog2(depth + 1);
    endfunction

endpackage

`default_nettype wire

/* hw/fetch_push_if.sv */
// Both interfaces carry plain levels; push and pop act on the clock edge, with no handshake
`default_nettype none

// Fetch control writes words here, the buffer reports its free entries back
interface fetch_push_if import fetch_pkg::*; #(
    parameter int IFB_DEPTH = 4                        // Must match the buffer depth
) ();
    logic                         push;                // One-cycle write strobe
    instr_t                       instr;
    fetch_status_e                status;
    logic                         flush;               // Clears the buffer on the same edge
    logic [free_w(IFB_DEPTH)-1:0] free;                // Registered, 0 to IFB_DEPTH

    modport producer (output push, output instr, output status, output flush, input free);
    modport buffer   (input push, input instr, input status, input flush, output free);
endinterface

// Buffer head toward the issue register
interface fetch_issue_if import fetch_pkg::*; ();
    logic          valid;                              // Buffer not empty
    instr_t        instr;                              // Head entry
    fetch_status_e status;
    logic          pop;                                // Head removed when valid too

    modport source (output valid, output instr, output status, input pop);
    modport sink   (input valid, input instr, input status, output pop);
endinterface

`default_nettype wire

/* hw/fetch_ctrl.sv */
// Needs a buffer of at least 3 entries; one address phase and one data phase in flight at most
`default_nettype none

module fetch_ctrl import fetch_pkg::*; #(
    parameter addr_t BOOT_ADD = '0                     // First address after reset
) (
    input  logic                  s_clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,             // Redirect from a later stage
    input  addr_t                 toc_add_i,           // Redirect target
    input  logic                  hready_i,
    input  logic                  hresp_i,
    input  instr_t                hrdata_i,
    output addr_t                 haddr_o,
    output htrans_e               htrans_o,
    fetch_push_if.producer        push_o
);
    // FE0 is the address phase, FE1 the data phase
    addr_t fe0_add_q, fe0_add_d;
    logic  fe0_utd_q, fe0_utd_d;                       // FE0 request is live
    addr_t fe1_add_q, fe1_add_d;
    logic  fe1_utd_q, fe1_utd_d;                       // FE1 data will be kept
    logic  fe1_park_q, fe1_park_d;                     // FE1 holds a target for FE0
    logic  ifb_room;                                   // Buffer space guaranteed at data return

    assign haddr_o  = fe0_add_q;
    assign htrans_o = fe0_utd_q ? HTRANS_NONSEQ : HTRANS_IDLE;

    // Data phase ends on hready, a flush drops it
    assign push_o.push   = hready_i & fe1_utd_q & ~flush_i;
    assign push_o.instr  = hrdata_i;
    assign push_o.status = hresp_i ? FETCH_BSERR : FETCH_VALID;
    assign push_o.flush  = flush_i;

    // Room for every word already in flight plus the new one
    assign ifb_room = ((push_o.free >= 1) & ~fe0_utd_q & ~fe1_utd_q)
                    | ((push_o.free >= 2) & (~fe0_utd_q | ~fe1_utd_q))
                    |  (push_o.free >= 3);

    always_comb begin : fe1_update
        fe1_add_d  = fe1_add_q;                        // Default hold
        fe1_utd_d  = fe1_utd_q;
        fe1_park_d = fe1_park_q;
        if (flush_i & ~hready_i & fe0_utd_q) begin
            // FE0 address is frozen on the bus, keep the target here for later
            fe1_add_d  = toc_add_i;
            fe1_utd_d  = 1'b0;
            fe1_park_d = 1'b1;
        end else if (flush_i | (hready_i & fe1_park_q)) begin
            fe1_utd_d  = 1'b0;                         // In-flight data is stale
            fe1_park_d = 1'b0;
        end else if (hready_i) begin
            fe1_add_d  = fe0_add_q;                    // Address phase moves on
            fe1_utd_d  = fe0_utd_q;
            fe1_park_d = 1'b0;
        end
    end

    always_comb begin : fe0_update
        fe0_add_d = fe0_add_q;
        fe0_utd_d = fe0_utd_q;
        if (~hready_i & fe0_utd_q) begin
            fe0_utd_d = 1'b1;                          // Bus stalls, address must stay
        end else if (flush_i) begin
            fe0_add_d = toc_add_i;                     // Buffer is flushed, room is certain
            fe0_utd_d = 1'b1;
        end else if (fe1_park_q) begin
            fe0_add_d = fe1_add_q;                     // Restore parked target
            fe0_utd_d = 1'b1;
        end else if (fe0_utd_q) begin
            fe0_add_d = fe0_add_q + ADDR_STEP;
            fe0_utd_d = ifb_room;
        end else begin
            fe0_utd_d = ifb_room;                      // Waiting for buffer space
        end
    end

    always_ff @(posedge s_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fe0_add_q  <= BOOT_ADD;                    // Picked up by the wait path
            fe0_utd_q  <= 1'b0;
            fe1_utd_q  <= 1'b0;
            fe1_park_q <= 1'b0;
        end else begin
            fe0_add_q  <= fe0_add_d;
            fe0_utd_q  <= fe0_utd_d;
            fe1_utd_q  <= fe1_utd_d;
            fe1_park_q <= fe1_park_d;
        end
    end

    // Data phase address or parked redirect target
    always_ff @(posedge s_clk_i) begin
        fe1_add_q <= fe1_add_d;
    end

endmodule

`default_nettype wire

/* hw/fetch_buffer.sv */
// IFB_DEPTH need not be a power of two; a push while free is zero would overwrite the head
`default_nettype none

module fetch_buffer import fetch_pkg::*; #(
    parameter int IFB_DEPTH = 4
) (
    input  logic           s_clk_i,
    input  logic           rst_n_i,
    fetch_push_if.buffer   push_i,
    fetch_issue_if.source  issue_o
);
    localparam int PTR_W  = $clog2(IFB_DEPTH);
    localparam int FREE_W = free_w(IFB_DEPTH);
    localparam logic [PTR_W-1:0]  LAST_PTR  = PTR_W'(IFB_DEPTH - 1);
    localparam logic [FREE_W-1:0] DEPTH_CNT = FREE_W'(IFB_DEPTH);

    ifb_entry_t        mem_q [IFB_DEPTH];              // Storage
    logic [PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
    logic [FREE_W-1:0] free_q;
    logic              not_empty;
    logic              pop_ok;                         // Head actually leaves

    assign not_empty = (free_q != DEPTH_CNT);
    assign pop_ok    = issue_o.pop & not_empty;

    assign push_i.free    = free_q;
    assign issue_o.valid  = not_empty;
    assign issue_o.instr  = mem_q[rd_ptr_q].instr;     // Head shown directly
    assign issue_o.status = mem_q[rd_ptr_q].status;

    always_ff @(posedge s_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            free_q   <= DEPTH_CNT;
        end else if (push_i.flush) begin
            // Flush beats any push or pop on the same edge
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            free_q   <= DEPTH_CNT;
        end else begin
            if (push_i.push)
                wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
            if (pop_ok)
                rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
            case ({push_i.push, pop_ok})
                2'b10:   free_q <= free_q - 1'b1;
                2'b01:   free_q <= free_q + 1'b1;
                default: free_q <= free_q;             // Both or neither
            endcase
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (push_i.push)
            mem_q[wr_ptr_q] <= '{status: push_i.status, instr: push_i.instr};
    end

endmodule

`default_nettype wire

/* hw/fetch_issue.sv */
// instr_o is only meaningful while instr_valid_o is high; bus_err_o is low for an empty slot
`default_nettype none

module fetch_issue import fetch_pkg::*; (
    input  logic          s_clk_i,
    input  logic          rst_n_i,
    input  logic          stall_i,                     // Decode cannot take a word
    input  logic          flush_i,
    fetch_issue_if.sink   issue_i,
    output instr_t        instr_o,
    output logic          instr_valid_o,
    output logic          bus_err_o
);
    ifb_entry_t head_q;                                // Word presented to decode
    logic       valid_q;

    // Take the head every cycle decode moves
    assign issue_i.pop = ~stall_i;

    assign instr_o       = head_q.instr;
    assign instr_valid_o = valid_q;
    assign bus_err_o     = valid_q & (head_q.status == FETCH_BSERR);

    always_ff @(posedge s_clk_i or negedge rst_n_i) begin
        if (!rst_n_i)
            valid_q <= 1'b0;
        else if (flush_i)
            valid_q <= 1'b0;                           // Old stream is gone
        else if (!stall_i)
            valid_q <= issue_i.valid;
    end

    always_ff @(posedge s_clk_i) begin
        if (!stall_i)
            head_q <= '{status: issue_i.status, instr: issue_i.instr};
    end

endmodule

`default_nettype wire

/* hw/fetch_top.sv */
// Word-aligned fetch only; hrdata_i and hresp_i are sampled on the edge where hready_i is high
`default_nettype none

module fetch_top import fetch_pkg::*; #(
    parameter addr_t BOOT_ADD  = 32'h0000_1000,
    parameter int    IFB_DEPTH = 4                     // At least 3
) (
    input  logic    s_clk_i,
    input  logic    rst_n_i,
    input  logic    stall_i,                           // Decode stall
    input  logic    flush_i,                           // Redirect pulse
    input  addr_t   toc_add_i,
    input  logic    hready_i,                          // AHB instruction bus
    input  logic    hresp_i,
    input  instr_t  hrdata_i,
    output addr_t   haddr_o,
    output htrans_e htrans_o,
    output instr_t  instr_o,                           // Toward decode
    output logic    instr_valid_o,
    output logic    bus_err_o
);
    fetch_push_if #(.IFB_DEPTH(IFB_DEPTH)) u_push_if ();
    fetch_issue_if                         u_issue_if ();

    fetch_ctrl #(.BOOT_ADD(BOOT_ADD)) u_ctrl (
        .s_clk_i   (s_clk_i),
        .rst_n_i   (rst_n_i),
        .flush_i   (flush_i),
        .toc_add_i (toc_add_i),
        .hready_i  (hready_i),
        .hresp_i   (hresp_i),
        .hrdata_i  (hrdata_i),
        .haddr_o   (haddr_o),
        .htrans_o  (htrans_o),
        .push_o    (u_push_if.producer)
    );

    fetch_buffer #(.IFB_DEPTH(IFB_DEPTH)) u_buffer (
        .s_clk_i (s_clk_i),
        .rst_n_i (rst_n_i),
        .push_i  (u_push_if.buffer),
        .issue_o (u_issue_if.source)
    );

    fetch_issue u_issue (
        .s_clk_i       (s_clk_i),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .issue_i       (u_issue_if.sink),
        .instr_o       (instr_o),
        .instr_valid_o (instr_valid_o),
        .bus_err_o     (bus_err_o)
    );

endmodule

`default_nettype wire

/* bench/fetch_assertions.sv */
// Bound into fetch_ctrl, which sees the bus and both sides of the push interface
`default_nettype none

module fetch_assertions import fetch_pkg::*; #(
    parameter int FREE_W = 3
) (
    input wire logic              clk_i,
    input wire logic              rst_n_i,
    input wire logic              hready_i,
    input wire htrans_e           htrans_i,
    input wire addr_t             haddr_i,
    input wire logic              push_i,
    input wire logic [FREE_W-1:0] free_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // Address phase frozen while the slave holds hready low
    addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (htrans_i == HTRANS_NONSEQ) && !hready_i |=> $stable(haddr_i))
        else $error("haddr changed while an address phase was waiting");

    no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> (free_i != '0))
        else $error("push into a full buffer");

    idle_in_reset: assert property (@(posedge clk_i)
        !rst_n_i |-> (htrans_i == HTRANS_IDLE))
        else $error("htrans not idle during reset");

endmodule

bind fetch_ctrl fetch_assertions #(.FREE_W($bits(push_o.free))) u_fetch_assertions (
    .clk_i    (s_clk_i),
    .rst_n_i  (rst_n_i),
    .hready_i (hready_i),
    .htrans_i (htrans_o),
    .haddr_i  (haddr_o),
    .push_i   (push_o.push),
    .free_i   (push_o.free)
);

`default_nettype wire

/* bench/fetch_tb.sv */
// Reads bench/fetch_cases.txt from the run directory; the slave model gives one-cycle error responses
`default_nettype none

module fetch_tb import fetch_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam addr_t   BOOT_ADD   = 32'h0000_1000;
    localparam int      IFB_DEPTH  = 4;
    localparam longint  CLK_PERIOD = 100;              // ns
    localparam longint  WORD_LIMIT = 40;               // Cycles allowed per checked word

    logic    s_clk_i;
    logic    rst_n_i;
    logic    stall_i;
    logic    flush_i;
    addr_t   toc_add_i;
    logic    hready_i;
    logic    hresp_i;
    instr_t  hrdata_i;
    addr_t   haddr_o;
    htrans_e htrans_o;
    instr_t  instr_o;
    logic    instr_valid_o;
    logic    bus_err_o;

    // Case table
    string names[$];
    addr_t targets[$];
    int    word_cnts[$];
    int    duties[$];
    addr_t err_adds[$];
    longint total_words = 0;
    bit     loaded = 0;

    // Slave model state, one data phase at most
    logic  dp_act = 1'b0;
    addr_t dp_addr = '0;
    addr_t cur_err = '1;

    // Reference model and stall pattern
    string cur_name = "";
    addr_t exp_addr;
    int    got;
    int    cur_duty = 0;
    int    stall_left = 0;
    int    errors = 0;
    int    checks = 0;
    bit    first_req = 1'b1;                           // First cycle after reset still ahead

    // Outputs as seen one cycle back, for the stall hold check
    logic   prev_stall = 1'b0;
    logic   prev_flush = 1'b0;
    logic   prev_valid = 1'b0;
    instr_t prev_instr = '0;

    fetch_top #(
        .BOOT_ADD  (BOOT_ADD),
        .IFB_DEPTH (IFB_DEPTH)
    ) u_dut (
        .s_clk_i       (s_clk_i),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .toc_add_i     (toc_add_i),
        .hready_i      (hready_i),
        .hresp_i       (hresp_i),
        .hrdata_i      (hrdata_i),
        .haddr_o       (haddr_o),
        .htrans_o      (htrans_o),
        .instr_o       (instr_o),
        .instr_valid_o (instr_valid_o),
        .bus_err_o     (bus_err_o)
    );

    initial s_clk_i = 1'b0;
    always #(CLK_PERIOD / 2) s_clk_i = ~s_clk_i;

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s %s expected %h actual %h", test, what, expected, actual);
        end
    endtask

    // AHB slave, answers the pending data phase and picks the next hready
    task automatic slave_step(input bit force_wait);
        logic rdy;
        rdy      = force_wait ? 1'b0 : (($urandom % 4) != 0);  // About 25% wait states
        hready_i = rdy;
        hrdata_i = ~dp_addr;                           // Data is the inverted address
        hresp_i  = dp_act && (dp_addr == cur_err);
        if (rdy) begin
            dp_act  = (htrans_o == HTRANS_NONSEQ);     // Address phase ends on this edge
            dp_addr = haddr_o;
        end
    endtask

    // Long stall stretches with the case's duty
    task automatic stall_step();
        if (stall_left == 0) begin
            stall_i    = (($urandom % 100) < cur_duty);
            stall_left = 1 + ($urandom % 8);
        end
        stall_left--;
    endtask

    // One falling edge: check holds, drive inputs, take a word if decode moves
    task automatic run_cycle(input bit flush_now, input bit force_wait, input addr_t target);
        @(negedge s_clk_i);
        if (prev_stall && !prev_flush) begin
            check_value(cur_name, "valid_hold", prev_valid, instr_valid_o);
            if (prev_valid)
                check_value(cur_name, "instr_hold", prev_instr, instr_o);
        end
        if (first_req) begin
            // Boot request is on the bus one cycle after reset release
            check_value(cur_name, "first_htrans", HTRANS_NONSEQ, htrans_o);
            check_value(cur_name, "first_haddr", BOOT_ADD, haddr_o);
            first_req = 1'b0;
        end
        flush_i   = flush_now;
        toc_add_i = target;
        stall_step();
        slave_step(force_wait);
        if (instr_valid_o && !stall_i && !flush_i) begin
            check_value(cur_name, "instr", ~exp_addr, instr_o);
            check_value(cur_name, "bus_err", exp_addr == cur_err, bus_err_o);
            exp_addr = exp_addr + ADDR_STEP;
            got++;
        end
        prev_stall = stall_i;
        prev_flush = flush_i;
        prev_valid = instr_valid_o;
        prev_instr = instr_o;
    endtask

    initial begin : main
        int    fd;
        int    rc;
        string line;
        string nm;
        addr_t tg;
        addr_t ea;
        int    nw;
        int    dt;
        rst_n_i   = 1'b0;
        stall_i   = 1'b0;
        flush_i   = 1'b0;
        toc_add_i = '0;
        hready_i  = 1'b1;
        hresp_i   = 1'b0;
        hrdata_i  = '0;
        void'($urandom(32'h947b524e));

        fd = $fopen("bench/fetch_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file bench/fetch_cases.txt");
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                if (rc > 1 && line[0] != "#") begin
                    rc = $sscanf(line, "%s %h %d %d %h", nm, tg, nw, dt, ea);
                    if (rc == 5) begin
                        names.push_back(nm);
                        targets.push_back(tg);
                        word_cnts.push_back(nw);
                        duties.push_back(dt);
                        err_adds.push_back(ea);
                        total_words += nw;
                    end
                end
            end
            $fclose(fd);
            if (names.size() == 0) begin
                errors++;
                $display("The case file holds no usable test line");
            end
            loaded = 1'b1;

            repeat (2) @(posedge s_clk_i);                 // Reset for 2 cycles
            @(negedge s_clk_i);
            check_value("reset", "htrans_idle", HTRANS_IDLE, htrans_o);
            check_value("reset", "valid_low", 1'b0, instr_valid_o);
            rst_n_i = 1'b1;

            foreach (names[i]) begin
                cur_name   = names[i];
                cur_duty   = duties[i];
                cur_err    = err_adds[i];
                stall_left = 0;
                got        = 0;
                exp_addr   = (i == 0) ? BOOT_ADD : targets[i];  // First case runs from reset
                if (i > 0)
                    run_cycle(1'b1, (i % 2) == 1, targets[i]);  // Odd cases flush during a wait
                while (got < word_cnts[i])
                    run_cycle(1'b0, 1'b0, targets[i]);
            end

            $display("%0d checks, %0d errors", checks, errors);
            if (errors == 0)
                $display("TESTBENCH PASSED");
            else
                $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Watchdog sized from the word count of all cases
    initial begin : watchdog
        wait (loaded);
        #(total_words * WORD_LIMIT * CLK_PERIOD);
        $display("Run timed out with words still missing in test %s", cur_name);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/fetch_cases.txt */
# name  flush_target(hex)  words  stall_percent  error_address(hex)
# The first line runs from reset without a flush, its target repeats the boot address
boot_seq        00001000  16   0  fffffffc
wait_states     00002000  20  10  fffffffc
long_stall      00002400  24  60  fffffffc
flush_in_wait   00003000  12  20  fffffffc
bus_error       00004000  12  10  00004008
error_first     00000100   4  30  00000100
wrap_region     fffffff0   8   0  fffffff8
near_boot       00001004  10  40  00001010
stall_error     00005000  14  50  00005014

/* tb.f */
hw/fetch_pkg.sv
hw/fetch_push_if.sv
hw/fetch_ctrl.sv
hw/fetch_buffer.sv
hw/fetch_issue.sv
hw/fetch_top.sv
bench/fetch_assertions.sv
bench/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch

sources:
  - hw/fetch_pkg.sv
  - hw/fetch_push_if.sv
  - hw/fetch_ctrl.sv
  - hw/fetch_buffer.sv
  - hw/fetch_issue.sv
  - hw/fetch_top.sv
  - target: simulation
    files:
      - bench/fetch_assertions.sv
      - bench/fetch_tb.sv
